// File: files.f
+incdir+test
verilog/dpPkg.sv
verilog/aluCore.sv
verilog/adderHoldReg.sv
verilog/accumWriteback.sv
verilog/statusReg.sv
verilog/datapath6502.sv
test/tbDatapath.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the datapath testbench with Verilator

cd "$(dirname "$0")" || exit 1
logFile=sim.log

verilator --binary --timing --assert -j 0 --top-module tbDatapath \
    -Mdir obj_dir -o simTb -f files.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/simTb > "$logFile" 2>&1
runStatus=$?
cat "$logFile"
if [ $runStatus -ne 0 ]; then
    echo "simulation exited with status $runStatus"
    exit 1
fi

if grep -q "Test failed" "$logFile"; then
    exit 1
fi
if ! grep -q "Test completed successfully" "$logFile"; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

// File: test/dpModel.svh
// reference model state, operation compute, writeback and per-edge update
`ifndef DP_MODEL_SVH
`define DP_MODEL_SVH

// accumulator and status as the DUT should show them
byteT   modelAcc;
statusT modelStat;
// operation sampled at the last edge, written at the next one
logic   pendValid;
aluOpT  pendOp;
byteT   pendResult;
logic   pendCarry;
logic   pendOverflow;

// ALU and decimal adjust from the state the operation sees
task automatic modelCompute(input aluOpT op, input byteT data);
    byteT       opB;
    logic       cin;
    logic [8:0] sum;
    logic       half;
    logic       decimal;
    opB = (op == opSbc || op == opCmp) ? ~data : data;
    cin = (op == opCmp) ? 1'b1 : ((op inside {opAdc, opSbc}) && modelStat[statusFlagC]);
    sum = 9'(modelAcc) + 9'(opB) + 9'(cin);
    half = (5'(modelAcc[3:0]) + 5'(opB[3:0]) + 5'(cin)) > 5'd15;
    decimal = modelStat[statusFlagD] && (op inside {opAdc, opSbc});
    pendOp = op;
    pendCarry = 1'b0;
    // sign of both inputs agree, sum disagrees
    pendOverflow = (modelAcc[7] == opB[7]) && (sum[7] != modelAcc[7]);
    case (op)
        opAdc, opSbc, opCmp: begin
            pendResult = sum[7:0];
            pendCarry = sum[8];
        end
        opAnd: pendResult = modelAcc & data;
        opOra: pendResult = modelAcc | data;
        opEor: pendResult = modelAcc ^ data;
        opLsr: begin
            pendResult = modelAcc >> 1;
            pendCarry = modelAcc[0];
        end
        default: pendResult = data;
    endcase
    if (decimal && op == opAdc) begin
        pendCarry = sum > {1'b0, bcdLimit};
        if (pendResult[3:0] > 4'd9 || half) begin
            pendResult = pendResult + nibbleAdjust;
        end
        if (pendCarry) begin
            pendResult = pendResult + byteAdjust;
        end
    end else if (decimal) begin
        // subtract borrows show as a clear carry
        if (!half) begin
            pendResult = pendResult - nibbleAdjust;
        end
        if (!pendCarry) begin
            pendResult = pendResult - byteAdjust;
        end
    end
    pendValid = 1'b1;
endtask

// one rising edge, inputs as sampled there
task automatic modelEdge();
    if (rstAll) begin
        modelAcc = 8'h00;
        modelStat = 8'h20;
        pendValid = 1'b0;
    end else if (!haltAll) begin
        if (setCarry) modelStat[statusFlagC] = 1'b1;
        if (clrCarry) modelStat[statusFlagC] = 1'b0;
        if (setDecimal) modelStat[statusFlagD] = 1'b1;
        if (clrDecimal) modelStat[statusFlagD] = 1'b0;
        if (clrOverflow) modelStat[statusFlagV] = 1'b0;
        // writeback lands after the strobes and wins
        if (pendValid) begin
            if (pendOp != opCmp) modelAcc = pendResult;
            modelStat[statusFlagN] = pendResult[7];
            modelStat[statusFlagZ] = (pendResult == 8'h00);
            if (pendOp inside {opAdc, opSbc, opCmp, opLsr}) modelStat[statusFlagC] = pendCarry;
            if (pendOp inside {opAdc, opSbc}) modelStat[statusFlagV] = pendOverflow;
        end
        if (opValid) begin
            modelCompute(aluOp, dataIn);
        end else begin
            pendValid = 1'b0;
        end
    end
endtask

`endif

// File: test/tbDatapath.sv
// testbench for datapath6502 with random and directed stimulus, model checks and timeout
`default_nettype none

module tbDatapath;
    timeunit 1ns;
    timeprecision 1ps;
    import dpPkg::*;

    localparam int resetCycles = 8;
    localparam int binaryOps = 300;
    localparam int bcdOps = 200;
    localparam int cmpOps = 24;
    localparam int strobeCycles = 24;
    localparam int haltCycles = 120;
    // loads, drains and single strobes between tests
    localparam int setupCycles = 30;
    localparam int cycleLimit = resetCycles + binaryOps + bcdOps + cmpOps + strobeCycles
                                + haltCycles + setupCycles + 50;

    logic   phi2 = 1'b0;
    logic   rstAll, haltAll, opValid;
    aluOpT  aluOp;
    byteT   dataIn;
    logic   setCarry, clrCarry, setDecimal, clrDecimal, clrOverflow;
    byteT   accum;
    statusT status;

    int cycleCount = 0;
    int checkCount = 0;
    int errorCount = 0;
    int testStart = 0;

    `include "dpModel.svh"

    datapath6502 #(.decimalEnable(1'b1)) dut0 (
        .phi2(phi2), .rstAll(rstAll), .haltAll(haltAll), .opValid(opValid),
        .aluOp(aluOp), .dataIn(dataIn), .setCarry(setCarry), .clrCarry(clrCarry),
        .setDecimal(setDecimal), .clrDecimal(clrDecimal), .clrOverflow(clrOverflow),
        .accum(accum), .status(status)
    );

    always #10 phi2 = ~phi2;

    always @(posedge phi2) cycleCount++;

    task automatic checkByte(input string name, input byteT got, input byteT expected);
        checkCount++;
        assert (got === expected) else begin
            $display("ERROR %s: got 0x%02h expected 0x%02h", name, got, expected);
            errorCount++;
        end
    endtask

    // step past one rising edge, compare with the model, then release the strobes
    task automatic nextCycle();
        @(negedge phi2);
        modelEdge();
        checkByte("accum", accum, modelAcc);
        checkByte("status", status, modelStat);
        opValid = 1'b0;
        {setCarry, clrCarry, setDecimal, clrDecimal, clrOverflow} = '0;
    endtask

    task automatic issueOp(input aluOpT op, input byteT data);
        opValid = 1'b1;
        aluOp = op;
        dataIn = data;
        nextCycle();
    endtask

    task automatic idleCycles(input int count);
        repeat (count) nextCycle();
    endtask

    task automatic reportTest(input string name);
        $display("%s: done, %0d errors", name, errorCount - testStart);
        testStart = errorCount;
    endtask

    function automatic byteT randomBcd();
        return {4'($urandom_range(9, 0)), 4'($urandom_range(9, 0))};
    endfunction

    function automatic aluOpT randomOp();
        return aluOpT'(3'($urandom_range(7, 0)));
    endfunction

    // watchdog on the edge count
    initial begin
        while (cycleCount < cycleLimit) @(posedge phi2);
        $display("simulation timed out after %0d cycles", cycleCount);
        $display("Test failed");
        $finish;
    end

    initial begin
        int   holdLeft;
        int   dropped;
        int   pick;
        byteT loaded;
        void'($urandom(61));
        {rstAll, haltAll, opValid} = 3'b100;
        aluOp = opLda;
        dataIn = 8'h00;
        {setCarry, clrCarry, setDecimal, clrDecimal, clrOverflow} = '0;
        holdLeft = 0;
        dropped = 0;

        idleCycles(resetCycles);
        rstAll = 1'b0;
        nextCycle();
        checkByte("accum", accum, 8'h00);
        checkByte("status", status, 8'h20);
        reportTest("reset values");

        // binary ops back to back, D clear from reset
        for (int i = 0; i < binaryOps; i++) issueOp(randomOp(), 8'($urandom));
        idleCycles(2);
        reportTest("binary ops");

        setDecimal = 1'b1;
        issueOp(opLda, randomBcd());
        for (int i = 0; i < bcdOps; i++) begin
            // occasional carry strobe alongside the op
            pick = int'($urandom_range(7, 0));
            if (pick == 0) setCarry = 1'b1;
            if (pick == 1) clrCarry = 1'b1;
            issueOp(pick[2] ? opSbc : opAdc, randomBcd());
        end
        idleCycles(2);
        clrDecimal = 1'b1;
        nextCycle();
        reportTest("decimal ops");

        loaded = 8'($urandom);
        issueOp(opLda, loaded);
        for (int i = 0; i < cmpOps; i++) issueOp(opCmp, (i == 0) ? loaded : 8'($urandom));
        idleCycles(2);
        checkByte("accum", accum, loaded);
        reportTest("compare");

        setCarry = 1'b1;
        nextCycle();
        checkByte("status.C", 8'(status[statusFlagC]), 8'h01);
        clrCarry = 1'b1;
        nextCycle();
        checkByte("status.C", 8'(status[statusFlagC]), 8'h00);
        setDecimal = 1'b1;
        nextCycle();
        checkByte("status.D", 8'(status[statusFlagD]), 8'h01);
        clrDecimal = 1'b1;
        nextCycle();
        checkByte("status.D", 8'(status[statusFlagD]), 8'h00);
        issueOp(opLda, 8'h7f);
        issueOp(opAdc, 8'h01);
        idleCycles(2);
        checkByte("status.V", 8'(status[statusFlagV]), 8'h01);
        clrOverflow = 1'b1;
        nextCycle();
        checkByte("status.V", 8'(status[statusFlagV]), 8'h00);
        // strobe at the writeback edge loses to the carry out
        issueOp(opLda, 8'h10);
        issueOp(opAdc, 8'h10);
        setCarry = 1'b1;
        nextCycle();
        checkByte("status.C", 8'(status[statusFlagC]), 8'h00);
        issueOp(opLda, 8'hf0);
        issueOp(opAdc, 8'h20);
        clrCarry = 1'b1;
        nextCycle();
        checkByte("status.C", 8'(status[statusFlagC]), 8'h01);
        // same for overflow, 7f + 01 + carry
        issueOp(opLda, 8'h7f);
        issueOp(opAdc, 8'h01);
        clrOverflow = 1'b1;
        nextCycle();
        checkByte("status.V", 8'(status[statusFlagV]), 8'h01);
        checkByte("accum", accum, 8'h81);
        reportTest("flag strobes");

        // halt level held for a few cycles at a time
        for (int i = 0; i < haltCycles; i++) begin
            if (holdLeft == 0) begin
                haltAll = 1'($urandom_range(1, 0));
                holdLeft = int'($urandom_range(6, 1));
            end
            holdLeft--;
            if (haltAll) dropped++;
            issueOp(randomOp(), 8'($urandom));
        end
        haltAll = 1'b0;
        idleCycles(2);
        // the stream has to meet at least one halted cycle
        checkCount++;
        assert (dropped > 0) else begin
            $display("halt was never asserted during the halt stream");
            errorCount++;
        end
        reportTest("halt");

        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/datapath6502.sv
// accumulator half of the 6502 datapath, ALU through hold stage to writeback and flags
`default_nettype none

module datapath6502 #(
    parameter bit decimalEnable = 1'b1
) (
    input  logic          phi2,
    input  logic          rstAll,
    input  logic          haltAll,
    input  logic          opValid,
    input  dpPkg::aluOpT  aluOp,
    input  dpPkg::byteT   dataIn,
    input  logic          setCarry,
    input  logic          clrCarry,
    input  logic          setDecimal,
    input  logic          clrDecimal,
    input  logic          clrOverflow,
    output dpPkg::byteT   accum,
    output dpPkg::statusT status
);
    import dpPkg::*;

    // ALU to hold stage
    byteT    aluResult;
    logic    aluCarry;
    logic    aluOverflow;
    logic    aluHalfCarry;
    adjKindT aluAdjust;

    // hold stage to writeback and flags
    logic    holdValid;
    aluOpT   holdOp;
    byteT    holdResult;
    logic    holdCarry;
    logic    holdOverflow;
    logic    holdHalfCarry;
    adjKindT holdAdjust;

    // writeback to flags
    byteT    wbResult;
    logic    wbCarry;

    // forwarded state back into the ALU
    byteT    accumNext;
    logic    carryNext;
    logic    decimalNext;

    aluCore #(
        .decimalEnable(decimalEnable)
    ) aluCore0 (
        .aluOp(aluOp), .dataIn(dataIn), .accumNext(accumNext),
        .carryNext(carryNext), .decimalNext(decimalNext),
        .aluResult(aluResult), .aluCarry(aluCarry), .aluOverflow(aluOverflow),
        .aluHalfCarry(aluHalfCarry), .aluAdjust(aluAdjust)
    );

    adderHoldReg adderHoldReg0 (
        .phi2(phi2), .rstAll(rstAll), .haltAll(haltAll), .opValid(opValid),
        .aluOp(aluOp), .aluResult(aluResult), .aluCarry(aluCarry),
        .aluOverflow(aluOverflow), .aluHalfCarry(aluHalfCarry), .aluAdjust(aluAdjust),
        .holdValid(holdValid), .holdOp(holdOp), .holdResult(holdResult),
        .holdCarry(holdCarry), .holdOverflow(holdOverflow),
        .holdHalfCarry(holdHalfCarry), .holdAdjust(holdAdjust)
    );

    accumWriteback accumWriteback0 (
        .phi2(phi2), .rstAll(rstAll), .haltAll(haltAll),
        .holdValid(holdValid), .holdOp(holdOp), .holdResult(holdResult),
        .holdCarry(holdCarry), .holdOverflow(holdOverflow),
        .holdHalfCarry(holdHalfCarry), .holdAdjust(holdAdjust),
        .wbResult(wbResult), .wbCarry(wbCarry), .accumNext(accumNext), .accum(accum)
    );

    statusReg statusReg0 (
        .phi2(phi2), .rstAll(rstAll), .haltAll(haltAll),
        .holdValid(holdValid), .holdOp(holdOp), .wbResult(wbResult),
        .wbCarry(wbCarry), .holdOverflow(holdOverflow),
        .setCarry(setCarry), .clrCarry(clrCarry), .setDecimal(setDecimal),
        .clrDecimal(clrDecimal), .clrOverflow(clrOverflow),
        .status(status), .carryNext(carryNext), .decimalNext(decimalNext)
    );

endmodule

`default_nettype wire

// File: verilog/statusReg.sv
// N V D Z C status register with writeback rules, flag strobes and next flag values
`default_nettype none

module statusReg (
    input  logic         phi2,
    input  logic         rstAll,
    input  logic         haltAll,
    input  logic         holdValid,
    input  dpPkg::aluOpT holdOp,
    input  dpPkg::byteT  wbResult,
    input  logic         wbCarry,
    input  logic         holdOverflow,
    input  logic         setCarry,
    input  logic         clrCarry,
    input  logic         setDecimal,
    input  logic         clrDecimal,
    input  logic         clrOverflow,
    output dpPkg::statusT status,
    output logic         carryNext,
    output logic         decimalNext
);
    import dpPkg::*;

    // bit 5 reads one, B and I read zero
    localparam statusT statusInit = 8'h20;

    statusT statusQ;
    statusT statusD;
    logic   carryOp;
    logic   overflowOp;

    // ops that produce a meaningful carry
    assign carryOp = holdOp inside {opAdc, opSbc, opCmp, opLsr};
    // only add and subtract report overflow
    assign overflowOp = holdOp inside {opAdc, opSbc};

    always_comb begin
        statusD = statusQ;
        // strobes first
        if (setCarry) begin
            statusD[statusFlagC] = 1'b1;
        end else if (clrCarry) begin
            statusD[statusFlagC] = 1'b0;
        end
        if (setDecimal) begin
            statusD[statusFlagD] = 1'b1;
        end else if (clrDecimal) begin
            statusD[statusFlagD] = 1'b0;
        end
        if (clrOverflow) begin
            statusD[statusFlagV] = 1'b0;
        end
        // writeback overrides a strobe on the same flag
        if (holdValid) begin
            statusD[statusFlagN] = wbResult[7];
            statusD[statusFlagZ] = (wbResult == 8'h00);
            if (carryOp) begin
                statusD[statusFlagC] = wbCarry;
            end
            if (overflowOp) begin
                statusD[statusFlagV] = holdOverflow;
            end
        end
    end

    always_ff @(posedge phi2) begin
        if (rstAll) begin
            statusQ <= statusInit;
        end else if (!haltAll) begin
            statusQ <= statusD;
        end
    end

    assign status = statusQ;

    // flags as they stand after the coming edge, fed forward to the ALU
    assign carryNext = rstAll ? statusInit[statusFlagC] :
                       haltAll ? statusQ[statusFlagC] : statusD[statusFlagC];
    assign decimalNext = rstAll ? statusInit[statusFlagD] :
                         haltAll ? statusQ[statusFlagD] : statusD[statusFlagD];

    carryStrobesExclusive: assert property (@(posedge phi2) disable iff (rstAll)
        !(setCarry && clrCarry))
        else $error("statusReg: carry set and clear strobed together");

    decimalStrobesExclusive: assert property (@(posedge phi2) disable iff (rstAll)
        !(setDecimal && clrDecimal))
        else $error("statusReg: decimal set and clear strobed together");

endmodule

`default_nettype wire

// File: verilog/accumWriteback.sv
// decimal adjust, accumulator register and forwarded next accumulator value
`default_nettype none

module accumWriteback (
    input  logic           phi2,
    input  logic           rstAll,
    input  logic           haltAll,
    input  logic           holdValid,
    input  dpPkg::aluOpT   holdOp,
    input  dpPkg::byteT    holdResult,
    input  logic           holdCarry,
    input  logic           holdOverflow,
    input  logic           holdHalfCarry,
    input  dpPkg::adjKindT holdAdjust,
    output dpPkg::byteT    wbResult,
    output logic           wbCarry,
    output dpPkg::byteT    accumNext,
    output dpPkg::byteT    accum
);
    import dpPkg::*;

    byteT accumQ;
    logic accumLoad;

    // BCD correction on the held binary result
    always_comb begin
        wbResult = holdResult;
        case (holdAdjust)
            adjAdd: begin
                // low digit overflowed past 9
                if (holdResult[3:0] > 4'd9 || holdHalfCarry) begin
                    wbResult = wbResult + nibbleAdjust;
                end
                // high digit overflowed, carry already says so
                if (holdCarry || holdResult > bcdLimit) begin
                    wbResult = wbResult + byteAdjust;
                end
            end
            adjSub: begin
                // borrow out of the low digit
                if (!holdHalfCarry) begin
                    wbResult = wbResult - nibbleAdjust;
                end
                // borrow out of the high digit
                if (!holdCarry) begin
                    wbResult = wbResult - byteAdjust;
                end
            end
            default: wbResult = holdResult;
        endcase
    end

    assign wbCarry = holdCarry;

    // compare only touches flags
    assign accumLoad = holdValid && (holdOp != opCmp);

    // value the accumulator holds after the coming edge
    always_comb begin
        if (rstAll) begin
            accumNext = '0;
        end else if (haltAll || !accumLoad) begin
            accumNext = accumQ;
        end else begin
            accumNext = wbResult;
        end
    end

    always_ff @(posedge phi2) begin
        if (rstAll) begin
            accumQ <= '0;
        end else if (!haltAll && accumLoad) begin
            accumQ <= wbResult;
        end
    end

    assign accum = accumQ;

endmodule

`default_nettype wire

// File: verilog/adderHoldReg.sv
// adder hold register for the ALU result, its flags and the operation tag
`default_nettype none

module adderHoldReg (
    input  logic           phi2,
    input  logic           rstAll,
    input  logic           haltAll,
    input  logic           opValid,
    input  dpPkg::aluOpT   aluOp,
    input  dpPkg::byteT    aluResult,
    input  logic           aluCarry,
    input  logic           aluOverflow,
    input  logic           aluHalfCarry,
    input  dpPkg::adjKindT aluAdjust,
    output logic           holdValid,
    output dpPkg::aluOpT   holdOp,
    output dpPkg::byteT    holdResult,
    output logic           holdCarry,
    output logic           holdOverflow,
    output logic           holdHalfCarry,
    output dpPkg::adjKindT holdAdjust
);
    import dpPkg::*;

    // valid bit, dropped strobes during halt never get in
    always_ff @(posedge phi2) begin
        if (rstAll) begin
            holdValid <= 1'b0;
        end else if (!haltAll) begin
            holdValid <= opValid;
        end
    end

    // payload follows the ALU every running cycle
    always_ff @(posedge phi2) begin
        if (!haltAll) begin
            holdOp        <= aluOp;
            holdResult    <= aluResult;
            holdCarry     <= aluCarry;
            holdOverflow  <= aluOverflow;
            holdHalfCarry <= aluHalfCarry;
            holdAdjust    <= aluAdjust;
        end
    end

    // decimal correction only ever travels with an add or a subtract
    adjustTagged: assert property (@(posedge phi2) disable iff (rstAll)
        (holdAdjust != adjNone) |-> (holdOp inside {opAdc, opSbc}))
        else $error("adderHoldReg: decimal adjust held for op %0d", holdOp);

endmodule

`default_nettype wire

// File: verilog/aluCore.sv
// operand selection, ALU and decimal adjust classification for one operation
`default_nettype none

module aluCore #(
    parameter bit decimalEnable = 1'b1
) (
    input  dpPkg::aluOpT   aluOp,
    input  dpPkg::byteT    dataIn,
    input  dpPkg::byteT    accumNext,
    input  logic           carryNext,
    input  logic           decimalNext,
    output dpPkg::byteT    aluResult,
    output logic           aluCarry,
    output logic           aluOverflow,
    output logic           aluHalfCarry,
    output dpPkg::adjKindT aluAdjust
);
    import dpPkg::*;

    // B side after optional inversion
    byteT       opB;
    logic       carryIn;
    // full 9-bit sum and low nibble sum
    logic [8:0] sum;
    logic [4:0] halfSum;
    // decimal mode is live only if the build allows it
    logic       decimalMode;

    // subtract and compare add the ones complement of the data byte
    assign opB = (aluOp == opSbc || aluOp == opCmp) ? ~dataIn : dataIn;

    always_comb begin
        case (aluOp)
            opAdc, opSbc: carryIn = carryNext;
            // compare is a subtract with no borrow in
            opCmp:        carryIn = 1'b1;
            default:      carryIn = 1'b0;
        endcase
    end

    assign sum     = {1'b0, accumNext} + {1'b0, opB} + {8'd0, carryIn};
    assign halfSum = {1'b0, accumNext[3:0]} + {1'b0, opB[3:0]} + {4'd0, carryIn};

    assign decimalMode = decimalEnable && decimalNext;

    always_comb begin
        aluResult    = sum[7:0];
        aluCarry     = 1'b0;
        aluOverflow  = 1'b0;
        aluHalfCarry = 1'b0;
        case (aluOp)
            opAdc, opSbc, opCmp: begin
                aluResult    = sum[7:0];
                aluCarry     = sum[8];
                // same operand signs but the sum flipped sign
                aluOverflow  = (accumNext[7] == opB[7]) && (sum[7] != accumNext[7]);
                aluHalfCarry = halfSum[4];
            end
            opAnd: aluResult = accumNext & dataIn;
            opOra: aluResult = accumNext | dataIn;
            opEor: aluResult = accumNext ^ dataIn;
            opLsr: begin
                // zero fill from the top, old bit 0 goes out as carry
                aluResult = {1'b0, accumNext[7:1]};
                aluCarry  = accumNext[0];
            end
            default: aluResult = dataIn;
        endcase
        // decimal add carries once the binary sum passes 99
        if (decimalMode && aluOp == opAdc) begin
            aluCarry = (sum > {1'b0, bcdLimit});
        end
    end

    always_comb begin
        aluAdjust = adjNone;
        if (decimalMode) begin
            if (aluOp == opAdc) begin
                aluAdjust = adjAdd;
            end else if (aluOp == opSbc) begin
                aluAdjust = adjSub;
            end
        end
    end

    // an unknown code would poison the hold register and both flag paths
    always_comb begin
        opKnown: assert (!$isunknown(aluOp))
            else $error("aluCore: operation code is unknown");
    end

endmodule

`default_nettype wire

// File: verilog/dpPkg.sv
// datapath types, operation enum, decimal adjust constants and status bit positions
`default_nettype none

package dpPkg;

    // one data byte on any datapath port
    typedef logic [7:0] byteT;

    // processor status byte, laid out as N V 1 B D I Z C
    typedef logic [7:0] statusT;

    // operations the accumulator half can run
    typedef enum logic [2:0] {
        opAdc = 3'd0,
        opSbc = 3'd1,
        opAnd = 3'd2,
        opOra = 3'd3,
        opEor = 3'd4,
        opLsr = 3'd5,
        opCmp = 3'd6,
        opLda = 3'd7
    } aluOpT;

    // which decimal correction the writeback stage applies
    typedef enum logic [1:0] {
        adjNone = 2'd0,
        adjAdd  = 2'd1,
        adjSub  = 2'd2
    } adjKindT;

    // largest valid two-digit BCD value, a decimal add above it carries
    localparam byteT bcdLimit = 8'h99;
    // low digit correction
    localparam byteT nibbleAdjust = 8'h06;
    // high digit correction
    localparam byteT byteAdjust = 8'h60;

    // flag positions inside statusT
    localparam int unsigned statusFlagN = 7;
    localparam int unsigned statusFlagV = 6;
    localparam int unsigned statusFlagD = 3;
    localparam int unsigned statusFlagZ = 1;
    localparam int unsigned statusFlagC = 0;

endpackage

`default_nettype wire
